/* list.f */
rtl/dcache_pkg.sv
rtl/tag_array.sv
rtl/data_array.sv
rtl/dcache_ctrl.sv
rtl/dcache_top.sv
verif/dcache_properties.sv
verif/dcache_tb.sv

/* run.sh */
#!/bin/sh
# build and run the dcache testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --top-module dcache_tb -Mdir obj_dir -f list.f
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/Vdcache_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "FAIL: see errors above" "$LOG"; then
    echo "simulation reported failure"
    exit 1
fi

echo "simulation passed"
exit 0

/* verif/dcache_tb.sv */
`timescale 1ns/100ps

module dcache_tb;

    localparam int NUM_RANDOM     = 400;
    localparam int NUM_OPS        = NUM_RANDOM + 6;     // random plus age test
    localparam int TIMEOUT_CYCLES = 20 + NUM_OPS * 60;
    localparam dcache_pkg::index_t AGE_SET = 6'd9;       // outside the random pool

    logic                 clk;
    logic                 resetn;
    logic                 req_valid;
    dcache_pkg::cpu_req_t req;
    logic                 req_ready;
    logic                 data_ok;
    dcache_pkg::word_t    rdata;
    logic                 rd_req;
    dcache_pkg::addr_t    rd_addr;
    logic                 ret_valid;
    logic                 ret_last;
    dcache_pkg::word_t    ret_data;
    logic                 wr_req;
    dcache_pkg::addr_t    wr_addr;
    dcache_pkg::line_t    wr_data;
    logic                 wr_valid;

    int unsigned checks = 0;
    int unsigned errors = 0;
    logic [15:0] lfsr   = 16'd16;

    dcache_pkg::word_t gold_mem [dcache_pkg::addr_t];   // every store applied at once
    dcache_pkg::word_t back_mem [dcache_pkg::addr_t];   // memory behind the cache
    logic [1:0]        m_valid [dcache_pkg::NUM_SETS];
    logic [1:0]        m_dirty [dcache_pkg::NUM_SETS];
    logic              m_age   [dcache_pkg::NUM_SETS];
    dcache_pkg::tag_t  m_tag   [dcache_pkg::NUM_SETS][2];

    dcache_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    function automatic logic [15:0] lfsr_next(logic [15:0] v);
        return v[0] ? ((v >> 1) ^ 16'hb400) : (v >> 1);
    endfunction

    // one lfsr step per bit
    function automatic logic [31:0] take_bits(int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
        return r;
    endfunction

    function automatic dcache_pkg::word_t fill_word(dcache_pkg::addr_t a);
        return (a * 32'h9e37_79b1) ^ 32'h5a5a_0f0f;
    endfunction

    function automatic dcache_pkg::word_t gold_word(dcache_pkg::addr_t a);
        return gold_mem.exists(a) ? gold_mem[a] : fill_word(a);
    endfunction

    function automatic dcache_pkg::word_t back_word(dcache_pkg::addr_t a);
        return back_mem.exists(a) ? back_mem[a] : fill_word(a);
    endfunction

    function automatic dcache_pkg::addr_t make_addr(dcache_pkg::tag_t t, dcache_pkg::index_t s,
                                                    dcache_pkg::word_sel_t w);
        return {t, s, w, 2'b00};
    endfunction

    task automatic check_value(input string name, input dcache_pkg::line_t expected,
                               input dcache_pkg::line_t actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("FAIL %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    task automatic expect_true(input logic ok, input string what);
        checks++;
        assert (ok) else begin
            errors++;
            $display("ERROR: %s", what);
        end
    endtask

    // one request predicted by the model and checked against the golden memory
    task automatic access(input string name, input logic op, input dcache_pkg::addr_t addr,
                          input dcache_pkg::strb_t wstrb, input dcache_pkg::word_t wdata,
                          output logic fetched);
        dcache_pkg::tag_t   t;
        dcache_pkg::index_t s;
        dcache_pkg::tag_t   old_tag;
        dcache_pkg::line_t  old_line;
        dcache_pkg::word_t  word;
        logic               hit;
        logic               way;
        logic               evict;
        logic               saw_wr;
        int                 cyc;
        int                 first_rd;
        int                 first_wr;
        t = addr[dcache_pkg::ADDR_W-1 -: dcache_pkg::TAG_W];
        s = addr[dcache_pkg::WORD_SEL_W+2 +: dcache_pkg::INDEX_W];
        hit = 1'b0;
        way = m_age[s];   // victim unless a way hits
        for (int w = 0; w < 2; w++) begin
            if (m_valid[s][w] && m_tag[s][w] == t) begin
                hit = 1'b1;
                way = 1'(w);
            end
        end
        evict   = !hit && m_valid[s][way] && m_dirty[s][way];
        old_tag = m_tag[s][way];
        for (int i = 0; i < dcache_pkg::WORDS_PER_LINE; i++) begin
            old_line[i*32 +: 32] = gold_word(make_addr(old_tag, s, 4'(i)));
        end
        while (!req_ready) step();
        req_valid = 1'b1;
        req = '{op: op, addr: addr, wstrb: wstrb, wdata: wdata};
        step();
        req_valid = 1'b0;
        word = gold_word(addr);
        if (op) begin
            for (int b = 0; b < 4; b++) begin
                if (wstrb[b]) word[b*8 +: 8] = wdata[b*8 +: 8];
            end
            gold_mem[addr] = word;
        end
        cyc = 1;
        fetched = 1'b0;
        saw_wr = 1'b0;
        first_rd = 0;
        first_wr = 0;
        forever begin
            if (rd_req && !fetched) begin
                fetched = 1'b1;
                first_rd = cyc;
                check_value({name, " rd_addr"}, dcache_pkg::line_t'({t, s, 6'b0}),
                            dcache_pkg::line_t'(rd_addr));
            end
            if (wr_req && !saw_wr) begin
                saw_wr = 1'b1;
                first_wr = cyc;
                check_value({name, " wr_addr"}, dcache_pkg::line_t'({old_tag, s, 6'b0}),
                            dcache_pkg::line_t'(wr_addr));
                check_value({name, " wr_data"}, old_line, wr_data);
            end
            if (data_ok) break;
            step();
            cyc++;
        end
        if (!op) begin
            check_value({name, " rdata"}, dcache_pkg::line_t'(word),
                        dcache_pkg::line_t'(rdata));
        end
        if (hit) begin
            check_value({name, " hit latency"}, dcache_pkg::line_t'(1),
                        dcache_pkg::line_t'(cyc));
            expect_true(!fetched && !saw_wr, {name, ": memory request on a predicted hit"});
        end else begin
            expect_true(fetched, {name, ": no rd_req on a predicted miss"});
            expect_true(saw_wr == evict, {name, ": wr_req does not match the victim's dirty state"});
            expect_true(!saw_wr || first_wr < first_rd, {name, ": wr_req came after rd_req"});
            m_valid[s][way] = 1'b1;
            m_tag[s][way]   = t;
            m_dirty[s][way] = 1'b0;
        end
        if (op) m_dirty[s][way] = 1'b1;
        m_age[s] = !way;
    endtask

    initial begin : stimulus
        dcache_pkg::tag_t   tag_pool [4];
        dcache_pkg::index_t idx_pool [2];
        logic               fetched;
        logic [1:0]         tsel;
        logic               isel;
        tag_pool = '{20'h00a11, 20'h3c0d2, 20'h7e5f3, 20'hb1004};
        idx_pool = '{6'd3, 6'd42};
        resetn = 1'b0;
        req_valid = 1'b0;
        req = '0;
        for (int i = 0; i < dcache_pkg::NUM_SETS; i++) begin
            m_valid[i] = '0;
            m_dirty[i] = '0;
            m_age[i]   = 1'b0;
        end
        repeat (10) @(posedge clk);
        #1;
        resetn = 1'b1;
        step();
        expect_true(req_ready && !data_ok && !rd_req && !wr_req, "outputs not idle after reset");

        // tags A, B, A, C in one set so C must take B's way
        access("age_victim", 1'b0, make_addr(20'h1a2b3, AGE_SET, 4'd0), '0, '0, fetched);
        expect_true(fetched, "first access to a set after reset did not miss");
        access("age_victim", 1'b0, make_addr(20'h4c5d6, AGE_SET, 4'd1), '0, '0, fetched);
        access("age_victim", 1'b1, make_addr(20'h1a2b3, AGE_SET, 4'd5), 4'b0110,
               32'hcafe_f00d, fetched);
        access("age_victim", 1'b0, make_addr(20'h7e8f9, AGE_SET, 4'd2), '0, '0, fetched);
        access("age_victim", 1'b0, make_addr(20'h1a2b3, AGE_SET, 4'd5), '0, '0, fetched);
        expect_true(!fetched, "tag A was fetched again, so C did not replace B");
        access("age_victim", 1'b0, make_addr(20'h4c5d6, AGE_SET, 4'd1), '0, '0, fetched);
        expect_true(fetched, "tag B still cached after C was filled");

        for (int n = 0; n < NUM_RANDOM; n++) begin
            tsel = 2'(take_bits(2));
            isel = 1'(take_bits(1));
            access("random", 1'(take_bits(1)),
                   make_addr(tag_pool[tsel], idx_pool[isel], 4'(take_bits(4))),
                   4'(take_bits(4)), take_bits(32), fetched);
        end

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) $display("PASS: all tests");
        else $display("FAIL: see errors above");
        $finish;
    end

    // memory model with random write-back and refill delays
    initial begin : responder
        int unsigned delay;
        ret_valid = 1'b0;
        ret_last = 1'b0;
        ret_data = '0;
        wr_valid = 1'b0;
        forever begin
            step();
            if (wr_req) begin
                for (int i = 0; i < dcache_pkg::WORDS_PER_LINE; i++) begin
                    back_mem[wr_addr + 32'(i*4)] = wr_data[i*32 +: 32];
                end
                delay = 1 + take_bits(2);
                repeat (delay - 1) step();
                wr_valid = 1'b1;
                step();
                wr_valid = 1'b0;
            end else if (rd_req) begin
                repeat (take_bits(2)) step();
                for (int i = 0; i < dcache_pkg::WORDS_PER_LINE; i++) begin
                    if (take_bits(1) != 0) begin
                        ret_valid = 1'b0;   // single-cycle gap
                        step();
                    end
                    ret_valid = 1'b1;
                    ret_last = (i == dcache_pkg::WORDS_PER_LINE - 1);
                    ret_data = back_word(rd_addr + 32'(i*4));
                    step();
                end
                ret_valid = 1'b0;
                ret_last = 1'b0;
            end
        end
    end

    initial begin : watchdog
        int unsigned cycles;
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        errors++;
        $display("timeout: the run did not finish within %0d cycles", cycles);
        $display("checks %0d, errors %0d", checks, errors);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

/* verif/dcache_properties.sv */
`timescale 1ns/100ps

module dcache_properties (
    input logic                    clk,
    input logic                    resetn,
    input logic                    rd_req,
    input logic                    wr_req,
    input logic                    ret_valid,
    input logic                    ret_last,
    input logic                    wr_valid,
    input logic                    data_ok,
    input dcache_pkg::ctrl_state_t state
);

    // one memory transfer at a time
    rd_wr_exclusive: assert property (@(posedge clk) disable iff (!resetn)
        !(rd_req && wr_req))
        else $error("rd_req and wr_req high in the same cycle");

    rd_req_held: assert property (@(posedge clk) disable iff (!resetn)
        rd_req && !(ret_valid && ret_last) |=> rd_req)
        else $error("rd_req dropped before the ret_last beat");

    wr_req_held: assert property (@(posedge clk) disable iff (!resetn)
        wr_req && !wr_valid |=> wr_req)
        else $error("wr_req dropped before wr_valid");

    refill_quiet: assert property (@(posedge clk) disable iff (!resetn)
        state == dcache_pkg::REFILL |-> !data_ok)
        else $error("data_ok high during REFILL");

endmodule

bind dcache_ctrl dcache_properties u_properties (
    .clk(clk), .resetn(resetn), .rd_req(rd_req), .wr_req(wr_req),
    .ret_valid(ret_valid), .ret_last(ret_last), .wr_valid(wr_valid),
    .data_ok(data_ok), .state(state)
);

/* rtl/dcache_top.sv */
`timescale 1ns/100ps

module dcache_top (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  req_valid,
    input  dcache_pkg::cpu_req_t  req,
    output logic                  req_ready,
    output logic                  data_ok,
    output dcache_pkg::word_t     rdata,
    output logic                  rd_req,
    output dcache_pkg::addr_t     rd_addr,
    input  logic                  ret_valid,
    input  logic                  ret_last,
    input  dcache_pkg::word_t     ret_data,
    output logic                  wr_req,
    output dcache_pkg::addr_t     wr_addr,
    output dcache_pkg::line_t     wr_data,
    input  logic                  wr_valid
);

    dcache_pkg::index_t     index;
    logic [1:0]             tag_we;
    dcache_pkg::tag_entry_t tag_wdata;
    logic [1:0]             dirty_we;
    logic                   dirty_wdata;
    dcache_pkg::tag_entry_t entry_0;
    dcache_pkg::tag_entry_t entry_1;
    logic                   dirty_0;
    logic                   dirty_1;
    dcache_pkg::line_strb_t data_we_0;
    dcache_pkg::line_strb_t data_we_1;
    dcache_pkg::line_t      data_wdata;
    dcache_pkg::line_t      line_0;
    dcache_pkg::line_t      line_1;

    dcache_ctrl u_ctrl (.*);

    // way 0 storage
    tag_array u_tag_0 (
        .clk, .resetn, .index,
        .tag_we(tag_we[0]), .tag_wdata,
        .dirty_we(dirty_we[0]), .dirty_wdata,
        .entry(entry_0), .dirty(dirty_0)
    );

    data_array u_data_0 (
        .clk, .index, .we(data_we_0), .wdata(data_wdata), .rdata(line_0)
    );

    // way 1 storage
    tag_array u_tag_1 (
        .clk, .resetn, .index,
        .tag_we(tag_we[1]), .tag_wdata,
        .dirty_we(dirty_we[1]), .dirty_wdata,
        .entry(entry_1), .dirty(dirty_1)
    );

    data_array u_data_1 (
        .clk, .index, .we(data_we_1), .wdata(data_wdata), .rdata(line_1)
    );

endmodule

/* rtl/dcache_ctrl.sv */
`timescale 1ns/100ps

module dcache_ctrl (
    input  logic                   clk,
    input  logic                   resetn,
    input  logic                   req_valid,
    input  dcache_pkg::cpu_req_t   req,
    output logic                   req_ready,
    output logic                   data_ok,
    output dcache_pkg::word_t      rdata,
    output logic                   rd_req,
    output dcache_pkg::addr_t      rd_addr,
    input  logic                   ret_valid,
    input  logic                   ret_last,
    input  dcache_pkg::word_t      ret_data,
    output logic                   wr_req,
    output dcache_pkg::addr_t      wr_addr,
    output dcache_pkg::line_t      wr_data,
    input  logic                   wr_valid,
    output dcache_pkg::index_t     index,
    output logic [1:0]             tag_we,
    output dcache_pkg::tag_entry_t tag_wdata,
    output logic [1:0]             dirty_we,
    output logic                   dirty_wdata,
    input  dcache_pkg::tag_entry_t entry_0,
    input  dcache_pkg::tag_entry_t entry_1,
    input  logic                   dirty_0,
    input  logic                   dirty_1,
    output dcache_pkg::line_strb_t data_we_0,
    output dcache_pkg::line_strb_t data_we_1,
    output dcache_pkg::line_t      data_wdata,
    input  dcache_pkg::line_t      line_0,
    input  dcache_pkg::line_t      line_1
);

    dcache_pkg::ctrl_state_t state, next_state;
    dcache_pkg::cpu_req_t    rb;         // request buffer
    dcache_pkg::tag_t        rb_tag;
    dcache_pkg::index_t      rb_index;
    dcache_pkg::word_sel_t   rb_word;
    dcache_pkg::word_sel_t   refill_cnt;
    logic [dcache_pkg::NUM_SETS-1:0] age;   // 1 = way 1 is the victim

    // miss buffer
    logic              mb_way;
    logic              mb_valid;
    logic              mb_dirty;
    dcache_pkg::tag_t  mb_tag;
    dcache_pkg::line_t mb_line;

    logic              hit_0, hit_1, hit, victim;
    dcache_pkg::line_t hit_line;
    dcache_pkg::line_strb_t store_mask, refill_mask;

    // 4 byte strobes moved to the lanes of one word
    function automatic dcache_pkg::line_strb_t lane_mask(dcache_pkg::strb_t strb,
                                                          dcache_pkg::word_sel_t sel);
        return dcache_pkg::line_strb_t'(strb) << {sel, 2'b00};
    endfunction

    // 2 low address bits are the byte offset
    assign rb_word  = rb.addr[2 +: dcache_pkg::WORD_SEL_W];
    assign rb_index = rb.addr[dcache_pkg::WORD_SEL_W + 2 +: dcache_pkg::INDEX_W];
    assign rb_tag   = rb.addr[dcache_pkg::WORD_SEL_W + dcache_pkg::INDEX_W + 2 +: dcache_pkg::TAG_W];

    assign hit_0  = entry_0.valid && (entry_0.tag == rb_tag);
    assign hit_1  = entry_1.valid && (entry_1.tag == rb_tag);
    assign hit    = hit_0 || hit_1;
    assign victim = age[rb_index];

    assign hit_line = hit_1 ? line_1 : line_0;
    assign rdata    = hit_line[rb_word * $bits(dcache_pkg::word_t) +: $bits(dcache_pkg::word_t)];

    assign store_mask  = lane_mask(rb.wstrb, rb_word);
    assign refill_mask = lane_mask(4'hf, refill_cnt);

    // arrays see the incoming set while idle so LOOKUP has it
    assign index = (state == dcache_pkg::IDLE) ?
                   req.addr[dcache_pkg::WORD_SEL_W + 2 +: dcache_pkg::INDEX_W] : rb_index;

    assign req_ready = (state == dcache_pkg::IDLE);
    assign data_ok   = (state == dcache_pkg::LOOKUP) && hit;
    assign rd_req    = (state == dcache_pkg::REFILL);
    assign wr_req    = (state == dcache_pkg::REPLACE);
    assign rd_addr   = {rb_tag, rb_index, {(dcache_pkg::WORD_SEL_W + 2){1'b0}}};
    assign wr_addr   = {mb_tag, rb_index, {(dcache_pkg::WORD_SEL_W + 2){1'b0}}};
    assign wr_data   = mb_line;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= dcache_pkg::IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            dcache_pkg::IDLE:    if (req_valid) next_state = dcache_pkg::LOOKUP;
            dcache_pkg::LOOKUP:  next_state = hit ? dcache_pkg::IDLE : dcache_pkg::MISS;
            dcache_pkg::MISS:    next_state = (mb_valid && mb_dirty) ?
                                              dcache_pkg::REPLACE : dcache_pkg::REFILL;
            dcache_pkg::REPLACE: if (wr_valid) next_state = dcache_pkg::REFILL;
            dcache_pkg::REFILL:  if (ret_valid && ret_last) next_state = dcache_pkg::RESTART;
            dcache_pkg::RESTART: next_state = dcache_pkg::LOOKUP;   // re-read refilled set
            default:             next_state = dcache_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            rb <= req;
        end
        if (state == dcache_pkg::LOOKUP && !hit) begin
            mb_way   <= victim;
            mb_valid <= victim ? entry_1.valid : entry_0.valid;
            mb_dirty <= victim ? dirty_1 : dirty_0;
            mb_tag   <= victim ? entry_1.tag : entry_0.tag;
            mb_line  <= victim ? line_1 : line_0;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            age        <= '0;
            refill_cnt <= '0;
        end else begin
            if (state == dcache_pkg::LOOKUP && hit) begin
                age[rb_index] <= hit_0;   // point away from the way just used
            end
            if (state == dcache_pkg::MISS) begin
                refill_cnt <= '0;
            end else if (state == dcache_pkg::REFILL && ret_valid) begin
                refill_cnt <= refill_cnt + 1'b1;
            end
        end
    end

    // store hit writes in LOOKUP, refill beats write in REFILL
    always_comb begin
        tag_we      = '0;
        tag_wdata   = '{valid: 1'b1, tag: rb_tag};
        dirty_we    = '0;
        dirty_wdata = 1'b0;
        data_we_0   = '0;
        data_we_1   = '0;
        data_wdata  = {dcache_pkg::WORDS_PER_LINE{ret_data}};
        if (state == dcache_pkg::LOOKUP && hit && rb.op) begin
            data_wdata  = {dcache_pkg::WORDS_PER_LINE{rb.wdata}};
            dirty_we    = {hit_1, hit_0};
            dirty_wdata = 1'b1;
            if (hit_0) data_we_0 = store_mask;
            else       data_we_1 = store_mask;
        end else if (state == dcache_pkg::REFILL && ret_valid) begin
            if (mb_way) data_we_1 = refill_mask;
            else        data_we_0 = refill_mask;
            if (ret_last) begin
                tag_we[mb_way]   = 1'b1;   // new tag valid, line clean
                dirty_we[mb_way] = 1'b1;
            end
        end
    end

endmodule

/* rtl/data_array.sv */
`timescale 1ns/100ps

module data_array (
    input  logic                   clk,
    input  dcache_pkg::index_t     index,
    input  dcache_pkg::line_strb_t we,
    input  dcache_pkg::line_t      wdata,
    output dcache_pkg::line_t      rdata
);

    dcache_pkg::line_t lines [dcache_pkg::NUM_SETS];

    // byte-enabled write
    always_ff @(posedge clk) begin
        for (int b = 0; b < $bits(dcache_pkg::line_strb_t); b++) begin
            if (we[b]) begin
                lines[index][b*8 +: 8] <= wdata[b*8 +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        rdata <= lines[index];   // read before write
    end

endmodule

/* rtl/tag_array.sv */
`timescale 1ns/100ps

module tag_array (
    input  logic                   clk,
    input  logic                   resetn,
    input  dcache_pkg::index_t     index,
    input  logic                   tag_we,
    input  dcache_pkg::tag_entry_t tag_wdata,
    input  logic                   dirty_we,
    input  logic                   dirty_wdata,
    output dcache_pkg::tag_entry_t entry,
    output logic                   dirty
);

    logic [dcache_pkg::NUM_SETS-1:0] valid_bits;
    logic [dcache_pkg::NUM_SETS-1:0] dirty_bits;
    dcache_pkg::tag_t                tags [dcache_pkg::NUM_SETS];

    always_ff @(posedge clk) begin
        if (tag_we) begin
            tags[index] <= tag_wdata.tag;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid_bits <= '0;
            dirty_bits <= '0;
        end else begin
            if (tag_we) valid_bits[index] <= tag_wdata.valid;
            if (dirty_we) dirty_bits[index] <= dirty_wdata;
        end
    end

    // registered read returns old contents on a same-cycle write
    always_ff @(posedge clk) begin
        if (!resetn) begin
            entry <= '0;
            dirty <= 1'b0;
        end else begin
            entry <= '{valid: valid_bits[index], tag: tags[index]};
            dirty <= dirty_bits[index];
        end
    end

endmodule

/* rtl/dcache_pkg.sv */
package dcache_pkg;

    // 2 ways, 64 sets, 16 words of 32 bits per line
    localparam int ADDR_W         = 32;
    localparam int TAG_W          = 20;
    localparam int INDEX_W        = 6;
    localparam int WORD_SEL_W     = 4;   // word inside a line
    localparam int NUM_SETS       = 64;
    localparam int WORDS_PER_LINE = 16;
    localparam int LINE_W         = 512;

    typedef logic [ADDR_W-1:0]     addr_t;
    typedef logic [TAG_W-1:0]      tag_t;
    typedef logic [INDEX_W-1:0]    index_t;
    typedef logic [WORD_SEL_W-1:0] word_sel_t;
    typedef logic [31:0]           word_t;
    typedef logic [3:0]            strb_t;
    typedef logic [LINE_W-1:0]     line_t;
    typedef logic [LINE_W/8-1:0]   line_strb_t;   // one bit per byte of a line

    // addr = {tag, index, word, byte}
    // wdata already sits in its byte lanes
    typedef struct packed {
        logic  op;      // 1 = store
        addr_t addr;
        strb_t wstrb;
        word_t wdata;
    } cpu_req_t;

    typedef struct packed {
        logic valid;
        tag_t tag;
    } tag_entry_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        MISS,
        REPLACE,
        REFILL,
        RESTART
    } ctrl_state_t;

endpackage
